/* tdm_switch_top.f */
tdm_frame_pkg.sv
tdm_host_pkg.sv
frame_timer.sv
stream_port.sv
switch_core.sv
tdm_switch_top.sv
tb_clock_gen.sv
tdm_switch_sva.sv
tdm_switch_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tdm_switch_tb
FILELIST = tdm_switch_top.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, check the log for a pass"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tdm_switch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tdm_switch_tb;

    localparam int N = 8;
    // Frames used by each test in turn
    localparam int TOTAL_FRAMES = 2 + 3 + 3 + 4 + 5;
    localparam real LIMIT_NS = 2.0 * TOTAL_FRAMES * 256 * 10;

    logic           clk_2048k;
    logic           g_rst;
    logic [N-1:0]   rx_stream;
    logic [N-1:0]   tx_stream;
    logic           frame_sync;
    logic           host_cs;
    logic           host_we;
    logic [7:0]     host_addr;
    logic [7:0]     host_wdata;
    logic [7:0]     host_rdata;

    // Reference model state
    logic [7:0] conn_map [8][32];
    logic [7:0] rx_hist [3][8][32];
    int         cyc;
    logic       check_tx;
    int         checks;
    int         errors;
    int         test_err;

    tb_clock_gen u_clk (
        .clk_2048k (clk_2048k),
        .g_rst     (g_rst)
    );

    tdm_switch_top #(
        .n_streams (N)
    ) DUT (
        .clk_2048k  (clk_2048k),
        .g_rst      (g_rst),
        .rx_stream  (rx_stream),
        .tx_stream  (tx_stream),
        .frame_sync (frame_sync),
        .host_cs    (host_cs),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    bind tdm_switch_top tdm_switch_sva #(
        .n_streams (n_streams)
    ) u_sva (
        .clk_2048k  (clk_2048k),
        .g_rst      (g_rst),
        .frame_sync (frame_sync),
        .host_cs    (host_cs),
        .host_we    (host_we),
        .host_rdata (host_rdata),
        .tx_stream  (tx_stream)
    );

    // ==================================================
    // Model and per-cycle step
    // ==================================================

    // Output bit from the switching rule
    function automatic logic expected_tx(input int k, input int c);
        int         f;
        int         n;
        int         b;
        int         src_f;
        logic [7:0] w;
        logic [7:0] d;
        f = c / 256;
        n = (c / 8) % 32;
        b = c % 8;
        w = conn_map[k][n];
        // Slot 0 is fetched in the previous frame, so it reaches two back
        src_f = (n > 0) ? f - 1 : f - 2;
        d = rx_hist[src_f % 3][w[7:5]][w[4:0]];
        return d[b];
    endfunction

    task automatic step();
        logic [N-1:0] rx;
        logic         exp_bit;
        int           n;
        int           b;
        rx = N'($urandom);
        rx_stream = rx;
        n = (cyc / 8) % 32;
        b = cyc % 8;
        for (int s = 0; s < N; s++)
            rx_hist[(cyc / 256) % 3][s][n][b] = rx[s];
        checks++;
        assert (frame_sync == ((cyc % 256) == 0))
        else
        begin
            $display("ERROR frame_sync cycle %0d: got %h expected %h",
                     cyc, frame_sync, (cyc % 256) == 0);
            errors++;
        end
        if (check_tx && cyc >= 512)
        begin
            for (int k = 0; k < N; k++)
            begin
                exp_bit = expected_tx(k, cyc);
                checks++;
                assert (tx_stream[k] === exp_bit)
                else
                begin
                    $display("ERROR tx_stream[%0d] cycle %0d: got %h expected %h",
                             k, cyc, tx_stream[k], exp_bit);
                    errors++;
                end
            end
        end
        @(posedge clk_2048k);
        #1;
        cyc++;
    endtask

    task automatic run_cycles(input int count);
        for (int i = 0; i < count; i++)
            step();
    endtask

    task automatic align_frame();
        while ((cyc % 256) != 0)
            step();
    endtask

    task automatic host_write(input int a, input logic [7:0] d);
        host_cs    = 1'b1;
        host_we    = 1'b1;
        host_addr  = 8'(a);
        host_wdata = d;
        conn_map[a / 32][a % 32] = d;
        step();
        host_cs = 1'b0;
        host_we = 1'b0;
    endtask

    task automatic report(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - test_err);
        test_err = errors;
    endtask

    // ==================================================
    // Tests
    // ==================================================

    initial
    begin
        logic [7:0] word;
        void'($urandom(36));
        rx_stream  = '0;
        host_cs    = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        cyc        = 0;
        check_tx   = 1'b0;
        checks     = 0;
        errors     = 0;
        test_err   = 0;

        // Test 1: reset state and frame timing
        repeat (5)
        begin
            @(negedge clk_2048k);
            checks++;
            assert (tx_stream == '0)
            else
            begin
                $display("ERROR tx_stream in reset: got %h expected %h", tx_stream, 8'h00);
                errors++;
            end
        end
        @(posedge g_rst);
        run_cycles(512);
        report(1, "reset and frame_sync");

        // Test 2: host writes and reads every address
        for (int a = 0; a < 256; a++)
            host_write(a, 8'($urandom));
        for (int a = 0; a <= 256; a++)
        begin
            host_cs = (a < 256);
            host_we = 1'b0;
            host_addr = 8'(a);
            step();
            if (a < 256)
            begin
                checks++;
                assert (host_rdata === conn_map[a / 32][a % 32])
                else
                begin
                    $display("ERROR host_rdata addr %h: got %h expected %h",
                             a, host_rdata, conn_map[a / 32][a % 32]);
                    errors++;
                end
            end
        end
        host_cs = 1'b0;
        report(2, "host access");

        // Test 3: random map, random data
        align_frame();
        check_tx = 1'b1;
        run_cycles(3 * 256);
        report(3, "switching");

        // Test 4: all outputs from one source
        check_tx = 1'b0;
        word = 8'($urandom);
        for (int a = 0; a < 256; a++)
            host_write(a, word);
        align_frame();
        run_cycles(256);
        check_tx = 1'b1;
        run_cycles(2 * 256);
        report(4, "broadcast");

        // Test 5: new map written in the middle of a frame
        run_cycles(100);
        check_tx = 1'b0;
        for (int a = 0; a < 256; a++)
            host_write(a, 8'($urandom));
        align_frame();
        run_cycles(256);
        check_tx = 1'b1;
        run_cycles(2 * 256);
        report(5, "reconfiguration");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // Watchdog sized from the frame count of all tests
    initial
    begin
        #(LIMIT_NS);
        $display("Timeout: the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tdm_switch_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module tdm_switch_sva
#(
    parameter int n_streams = 8
)
(
    input wire logic                 clk_2048k,
    input wire logic                 g_rst,
    input wire logic                 frame_sync,
    input wire logic                 host_cs,
    input wire logic                 host_we,
    input wire logic [7:0]           host_rdata,
    input wire logic [n_streams-1:0] tx_stream
);

    // Cycles since the last frame start
    int  gap;
    logic seen;

    always_ff @(posedge clk_2048k or negedge g_rst)
    begin
        if (!g_rst)
        begin
            gap  <= 0;
            seen <= 1'b0;
        end
        else if (frame_sync)
        begin
            gap  <= 0;
            seen <= 1'b1;
        end
        else
        begin
            gap <= gap + 1;
        end
    end

    // ==================================================
    // Frame timing
    // ==================================================

    a_sync_period: assert property (@(posedge clk_2048k) disable iff (!g_rst)
        (frame_sync && seen) |-> (gap == 255))
        else $error("frame_sync period is not 256 cycles");

    a_sync_not_late: assert property (@(posedge clk_2048k) disable iff (!g_rst)
        seen |-> (gap < 256))
        else $error("frame_sync missing after 256 cycles");

    // ==================================================
    // Host read and reset state
    // ==================================================

    a_rdata_known: assert property (@(posedge clk_2048k) disable iff (!g_rst)
        (host_cs && !host_we) |=> !$isunknown(host_rdata))
        else $error("host_rdata unknown after a read");

    a_tx_reset: assert property (@(posedge clk_2048k)
        !g_rst |-> (tx_stream == '0))
        else $error("tx_stream not zero in reset");

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
    output logic clk_2048k,
    output logic g_rst
);

    // 10 ns period
    initial
    begin
        clk_2048k = 1'b0;
        forever #5 clk_2048k = ~clk_2048k;
    end

    // Reset held for 10 cycles, released just after an edge
    initial
    begin
        g_rst = 1'b0;
        repeat (10) @(posedge clk_2048k);
        #1 g_rst = 1'b1;
    end

endmodule

`default_nettype wire

/* tdm_switch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tdm_switch_top
    import tdm_frame_pkg::*, tdm_host_pkg::*;
#(
    parameter int n_streams = 8
)
(
    input  wire logic                 clk_2048k,
    input  wire logic                 g_rst,
    input  wire logic [n_streams-1:0] rx_stream,
    output wire logic [n_streams-1:0] tx_stream,
    output wire logic                 frame_sync,
    input  wire logic                 host_cs,
    input  wire logic                 host_we,
    input  wire host_addr_t           host_addr,
    input  wire byte_t                host_wdata,
    output wire byte_t                host_rdata
);

    // Stream count has to fit in the connection word
    if (n_streams < 1 || n_streams > MAX_STREAMS)
        $error("n_streams out of range: %0d", n_streams);

    wire bit_idx_t              bit_cnt;
    wire slot_idx_t             slot_cnt;
    wire logic                  slot_last;
    wire byte_t [n_streams-1:0] rx_bytes;
    wire byte_t [n_streams-1:0] tx_bytes;

    // ==================================================
    // Frame timing
    // ==================================================

    frame_timer u_timer (
        .clk_2048k  (clk_2048k),
        .g_rst      (g_rst),
        .bit_cnt    (bit_cnt),
        .slot_cnt   (slot_cnt),
        .slot_last  (slot_last),
        .frame_sync (frame_sync)
    );

    // ==================================================
    // Serial stream ports
    // ==================================================

    for (genvar i = 0; i < n_streams; i++)
    begin : g_port
        stream_port u_port (
            .clk_2048k (clk_2048k),
            .g_rst     (g_rst),
            .slot_last (slot_last),
            .rx_bit    (rx_stream[i]),
            .rx_byte   (rx_bytes[i]),
            .tx_byte   (tx_bytes[i]),
            .tx_bit    (tx_stream[i])
        );
    end

    // ==================================================
    // Switch core
    // ==================================================

    switch_core #(
        .n_streams (n_streams)
    ) u_core (
        .clk_2048k  (clk_2048k),
        .g_rst      (g_rst),
        .bit_cnt    (bit_cnt),
        .slot_cnt   (slot_cnt),
        .rx_bytes   (rx_bytes),
        .tx_bytes   (tx_bytes),
        .host_cs    (host_cs),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

endmodule

`default_nettype wire

/* switch_core.sv */
`timescale 1ns/1ps
`default_nettype none

module switch_core
    import tdm_frame_pkg::*, tdm_host_pkg::*;
#(
    parameter int n_streams = 8
)
(
    input  wire logic                  clk_2048k,
    input  wire logic                  g_rst,
    input  wire bit_idx_t              bit_cnt,
    input  wire slot_idx_t             slot_cnt,
    input  wire byte_t [n_streams-1:0] rx_bytes,
    output byte_t [n_streams-1:0]      tx_bytes,
    input  wire logic                  host_cs,
    input  wire logic                  host_we,
    input  wire host_addr_t            host_addr,
    input  wire byte_t                 host_wdata,
    output byte_t                      host_rdata
);

    // Two pages, one being written while the other is read
    byte_t      data_mem [2][MAX_STREAMS][SLOTS_PER_FRAME];
    conn_word_u conn_mem [MAX_STREAMS][SLOTS_PER_FRAME];

    logic        wr_page;
    logic        rd_page;
    logic        slot_end;
    logic        fetch_now;
    logic        frame_end;
    slot_idx_t   next_slot;
    conn_word_u  fetch_word [n_streams];

    stream_idx_t host_stream;
    slot_idx_t   host_slot;
    logic        host_in_range;
    conn_word_u  host_word;

    // ==================================================
    // Slot timing
    // ==================================================

    assign slot_end  = (bit_cnt == bit_idx_t'(BITS_PER_SLOT - 1));
    // One bit ahead of slot end, so the port can load on time
    assign fetch_now = (bit_cnt == bit_idx_t'(BITS_PER_SLOT - 2));
    assign frame_end = slot_end && (slot_cnt == slot_idx_t'(SLOTS_PER_FRAME - 1));
    assign next_slot = slot_cnt + 1'b1;

    // Swap pages after the last writes of the frame
    always_ff @(posedge clk_2048k or negedge g_rst)
    begin
        if (!g_rst)
            wr_page <= 1'b0;
        else if (frame_end)
            wr_page <= ~wr_page;
    end

    assign rd_page = ~wr_page;

    // ==================================================
    // Data memory write
    // ==================================================

    always_ff @(posedge clk_2048k)
    begin
        if (slot_end)
        begin
            for (int s = 0; s < n_streams; s++)
                data_mem[wr_page][s][slot_cnt] <= rx_bytes[s];
        end
    end

    // ==================================================
    // Per-slot fetch through the connection memory
    // ==================================================

    always_comb
    begin
        for (int k = 0; k < n_streams; k++)
            fetch_word[k] = conn_mem[k][next_slot];
    end

    always_ff @(posedge clk_2048k or negedge g_rst)
    begin
        if (!g_rst)
        begin
            tx_bytes <= '0;
        end
        else if (fetch_now)
        begin
            // Source named by the word for this stream and the next slot
            for (int k = 0; k < n_streams; k++)
                tx_bytes[k] <= data_mem[rd_page][fetch_word[k].sel.src_stream]
                                       [fetch_word[k].sel.src_slot];
        end
    end

    // ==================================================
    // Host port
    // ==================================================

    assign {host_stream, host_slot} = host_addr;
    assign host_in_range  = (int'(host_stream) < n_streams);
    assign host_word.raw  = host_wdata;

    always_ff @(posedge clk_2048k)
    begin
        if (host_cs && host_we && host_in_range)
            conn_mem[host_stream][host_slot] <= host_word;
    end

    // Read data lands one cycle after the request and holds
    always_ff @(posedge clk_2048k or negedge g_rst)
    begin
        if (!g_rst)
        begin
            host_rdata <= '0;
        end
        else if (host_cs && !host_we)
        begin
            if (host_in_range)
                host_rdata <= conn_mem[host_stream][host_slot].raw;
            else
                host_rdata <= '0;  // unused streams read as zero
        end
    end

endmodule

`default_nettype wire

/* stream_port.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_port
    import tdm_frame_pkg::*;
(
    input  wire logic  clk_2048k,
    input  wire logic  g_rst,
    input  wire logic  slot_last,
    input  wire logic  rx_bit,
    output byte_t      rx_byte,
    input  wire byte_t tx_byte,
    output logic       tx_bit
);

    // Seven bits held; the eighth is the live input bit
    logic [BITS_PER_SLOT-2:0] rx_shift;
    byte_t                    tx_shift;

    // ==================================================
    // Receive side
    // ==================================================

    // LSB arrives first, so bits move down towards bit 0
    always_ff @(posedge clk_2048k)
    begin
        rx_shift <= {rx_bit, rx_shift[BITS_PER_SLOT-2:1]};
    end

    // Complete byte in the cycle of the last bit
    assign rx_byte = {rx_bit, rx_shift};

    // ==================================================
    // Transmit side
    // ==================================================

    // Load at slot end, then shift out LSB first with zero fill
    always_ff @(posedge clk_2048k or negedge g_rst)
    begin
        if (!g_rst)
        begin
            tx_shift <= '0;
        end
        else if (slot_last)
        begin
            tx_shift <= tx_byte;
        end
        else
        begin
            tx_shift <= {1'b0, tx_shift[BITS_PER_SLOT-1:1]};
        end
    end

    assign tx_bit = tx_shift[0];

endmodule

`default_nettype wire

/* frame_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_timer
    import tdm_frame_pkg::*;
(
    input  wire logic clk_2048k,
    input  wire logic g_rst,
    output bit_idx_t  bit_cnt,
    output slot_idx_t slot_cnt,
    output logic      slot_last,
    output logic      frame_sync
);

    // ==================================================
    // Bit and slot counters
    // ==================================================

    always_ff @(posedge clk_2048k or negedge g_rst)
    begin
        if (!g_rst)
        begin
            bit_cnt  <= '0;
            slot_cnt <= '0;
        end
        else
        begin
            if (slot_last)
            begin
                bit_cnt <= '0;
                // Wrap at the end of the frame
                if (slot_cnt == slot_idx_t'(SLOTS_PER_FRAME - 1))
                    slot_cnt <= '0;
                else
                    slot_cnt <= slot_cnt + 1'b1;
            end
            else
            begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // ==================================================
    // Strobes decoded from the counters
    // ==================================================

    // Last bit of every slot
    assign slot_last = (bit_cnt == bit_idx_t'(BITS_PER_SLOT - 1));

    // First bit of slot 0
    assign frame_sync = (slot_cnt == '0) && (bit_cnt == '0);

endmodule

`default_nettype wire

/* tdm_host_pkg.sv */
`default_nettype none

package tdm_host_pkg;

    import tdm_frame_pkg::*;

    // ==================================================
    // Host address and connection word
    // ==================================================

    // Upper bits pick the output stream, lower bits the output slot
    typedef logic [7:0] host_addr_t;

    // Host sees a plain byte, the switch path sees source fields
    typedef union packed {
        byte_t raw;
        struct packed {
            stream_idx_t src_stream;
            slot_idx_t   src_slot;
        } sel;
    } conn_word_u;

    // Both views have to line up bit for bit
    localparam int CONN_WORD_BITS = $bits(conn_word_u);

    // Address splits into the same two fields as the connection word
    localparam int HOST_ADDR_BITS = $bits(host_addr_t);

endpackage

`default_nettype wire

/* tdm_frame_pkg.sv */
`default_nettype none

package tdm_frame_pkg;

    // ==================================================
    // Frame geometry
    // ==================================================

    // One slot is a byte, sent LSB first
    localparam int BITS_PER_SLOT = 8;

    // 32 slots make one 125 us frame at 2.048 Mbit/s
    localparam int SLOTS_PER_FRAME = 32;

    // Widest stream count the connection word can address
    localparam int MAX_STREAMS = 8;

    // ==================================================
    // Index and payload types
    // ==================================================

    typedef logic [$clog2(BITS_PER_SLOT)-1:0]   bit_idx_t;
    typedef logic [$clog2(SLOTS_PER_FRAME)-1:0] slot_idx_t;
    typedef logic [$clog2(MAX_STREAMS)-1:0]     stream_idx_t;

    typedef logic [BITS_PER_SLOT-1:0] byte_t;

endpackage

`default_nettype wire
